// File: executeUnit.sv
//*********************************************************************
// Decode and execute share one stage. Unknown opcodes pass as no-ops.
// Jump and branch targets are not checked for alignment.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module executeUnit import rvPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   decValid,
  input  wordT   decInst,
  input  wordT   decPc,
  output logic   redirect,
  output wordT   redirectPc,
  operandIf.exec operands,
  resultIf.source result
);
  logic    exValid;  // execute slot holds a live instruction
  wordT    exInst;
  wordT    exPc;
  opcodeT  opcode;
  funct3T  funct3;
  regAddrT rd;
  wordT    immI;
  wordT    immU;
  wordT    immB;
  wordT    immJ;
  wordT    opB;
  wordT    aluOut;
  logic    branchTaken;
  logic    writes;   // opcode writes rd
  wordT    writeData;

  // execute register drops the decode slot while it is flushed
  always_ff @(posedge clk)
  begin
    if (reset)
      exValid <= 1'b0;
    else
      exValid <= decValid && !redirect;
  end

  always_ff @(posedge clk)
  begin
    exInst <= decInst;
    exPc <= decPc;
  end

  assign opcode = exInst[6:0];
  assign funct3 = exInst[14:12];
  assign rd = exInst[11:7];
  assign operands.rs1 = exInst[19:15];
  assign operands.rs2 = exInst[24:20];

  // I, B and J immediates sign extended from inst[31]
  assign immI = {{20{exInst[31]}}, exInst[31:20]};
  assign immU = {exInst[31:12], 12'b0};
  assign immB = {{20{exInst[31]}}, exInst[7], exInst[30:25], exInst[11:8], 1'b0};
  assign immJ = {{12{exInst[31]}}, exInst[19:12], exInst[20], exInst[30:21], 1'b0};

  assign opB = (opcode == OpCompute) ? operands.rs2Data : immI;

  always_comb
  begin
    case (funct3)
      F3Add:
        if ((opcode == OpCompute) && exInst[30])
          aluOut = operands.rs1Data - opB;  // no subi in RV32I
        else
          aluOut = operands.rs1Data + opB;
      F3Sll:  aluOut = operands.rs1Data << opB[4:0];  // shamt from low five bits
      F3Slt:  aluOut = {31'b0, $signed(operands.rs1Data) < $signed(opB)};
      F3Sltu: aluOut = {31'b0, operands.rs1Data < opB};
      F3Xor:  aluOut = operands.rs1Data ^ opB;
      F3Sr:
        if (exInst[30])
          aluOut = $signed(operands.rs1Data) >>> opB[4:0];
        else
          aluOut = operands.rs1Data >> opB[4:0];
      F3Or:   aluOut = operands.rs1Data | opB;
      default: aluOut = operands.rs1Data & opB;  // F3And
    endcase
  end

  // branch compare always on the two registers
  always_comb
  begin
    case (funct3)
      F3Beq:  branchTaken = (operands.rs1Data == operands.rs2Data);
      F3Bne:  branchTaken = (operands.rs1Data != operands.rs2Data);
      F3Blt:  branchTaken = ($signed(operands.rs1Data) < $signed(operands.rs2Data));
      F3Bge:  branchTaken = ($signed(operands.rs1Data) >= $signed(operands.rs2Data));
      F3Bltu: branchTaken = (operands.rs1Data < operands.rs2Data);
      F3Bgeu: branchTaken = (operands.rs1Data >= operands.rs2Data);
      default: branchTaken = 1'b0;  // reserved encodings never branch
    endcase
  end

  always_comb
  begin
    writes = 1'b1;
    writeData = aluOut;
    case (opcode)
      OpCompute, OpImm: writeData = aluOut;
      OpLui: writeData = immU;
      OpJal: writeData = exPc + 32'd4;  // return address
      default: writes = 1'b0;           // branches and unknown opcodes
    endcase
  end

  // predicted not taken, so any taken control transfer is a mispredict
  assign redirect = exValid && ((opcode == OpJal) || ((opcode == OpBranch) && branchTaken));
  assign redirectPc = exPc + ((opcode == OpJal) ? immJ : immB);

  assign result.valid = exValid;
  assign result.writeEn = exValid && writes && (rd != '0);  // x0 never written
  assign result.dst = rd;
  assign result.data = writeData;

  // the word fetched alongside a redirect never reaches decode
  assert property (@(posedge clk) disable iff (reset) redirect |=> !decValid)
    else $error("redirect left the fetched word live");

endmodule

`default_nettype wire

// File: fetchUnit.sv
//*********************************************************************
// instWord must belong to instAddr in the same cycle. Fetch stops at
// the first zero word unless an older branch redirects it.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import rvPkg::*;
#(
  parameter wordT ResetPc = '0
)
(
  input  logic clk,
  input  logic reset,
  output wordT instAddr,
  input  wordT instWord,
  output logic decValid,
  output wordT decInst,
  output wordT decPc,
  input  logic redirect,
  input  wordT redirectPc,
  input  logic drained,
  output logic halt
);
  fetchStateT state;
  wordT       pc;
  logic       settled;  // stopped a full cycle so execute is empty too

  assign instAddr = pc;
  assign halt = (state == FetchHalted);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= FetchRun;
      pc <= ResetPc;
      decValid <= 1'b0;
      settled <= 1'b0;
    end
    else
    begin
      decValid <= 1'b0;  // slot stays empty unless a good word is taken
      settled <= 1'b0;
      if (redirect)
      begin
        // voids the word being fetched now, execute drops the one in decode
        pc <= redirectPc;
        state <= FetchRun;  // a zero word on the wrong path is forgotten
      end
      else
      begin
        case (state)
          FetchRun:
            if (instWord == '0)
              state <= FetchStopped;  // pc holds on the zero word
            else
            begin
              pc <= pc + 32'd4;
              decValid <= 1'b1;
            end
          FetchStopped:
          begin
            settled <= 1'b1;
            if (settled && drained)
              state <= FetchHalted;
          end
          default:
            state <= state;  // halted until reset
        endcase
      end
    end
  end

  // decode payload, qualified by decValid
  always_ff @(posedge clk)
  begin
    decInst <= instWord;
    decPc <= pc;
  end

  // targets from execute must keep the fetch address on a word boundary
  assert property (@(posedge clk) disable iff (reset) instAddr[1:0] == 2'b00)
    else $error("fetch address not word aligned");

endmodule

`default_nettype wire

// File: pipelineCpu.sv
//*********************************************************************
// Five stage RV32I core, integer ops, branches, JAL and LUI only.
// instWord must answer instAddr in the same cycle. halt stays high
// until reset.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu import rvPkg::*;
#(
  parameter wordT ResetPc = '0
)
(
  input  logic    clk,
  input  logic    reset,
  output wordT    instAddr,
  input  wordT    instWord,
  output logic    halt,
  output logic    retireValid,
  output regAddrT retireDst,
  output wordT    retireData
);
  logic decValid;
  wordT decInst;
  wordT decPc;
  logic redirect;    // one cycle flush pulse from execute
  wordT redirectPc;
  logic drained;     // memory and writeback slots empty

  operandIf operands ();
  resultIf  results ();

  fetchUnit #(.ResetPc(ResetPc)) i_fetchUnit
  (
    .clk(clk), .reset(reset),
    .instAddr(instAddr), .instWord(instWord),
    .decValid(decValid), .decInst(decInst), .decPc(decPc),
    .redirect(redirect), .redirectPc(redirectPc),
    .drained(drained), .halt(halt)
  );

  executeUnit i_executeUnit
  (
    .clk(clk), .reset(reset),
    .decValid(decValid), .decInst(decInst), .decPc(decPc),
    .redirect(redirect), .redirectPc(redirectPc),
    .operands(operands), .result(results)
  );

  writebackUnit i_writebackUnit
  (
    .clk(clk), .reset(reset),
    .operands(operands), .result(results),
    .retireValid(retireValid), .retireDst(retireDst), .retireData(retireData),
    .drained(drained)
  );

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# Builds and runs the pipeline testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tbPipelineCpu -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0

// File: rvPkg.sv
//*********************************************************************
// Types and encodings for the RV32I integer subset of the pipeline.
// Only the opcodes below are decoded. Loads, stores, JALR and AUIPC
// fall through as no-ops.
//*********************************************************************
`default_nettype none

package rvPkg;

  typedef logic [31:0] wordT;     // data word or byte address
  typedef logic [4:0]  regAddrT;  // register index, x0..x31
  typedef logic [6:0]  opcodeT;   // inst[6:0]
  typedef logic [2:0]  funct3T;   // inst[14:12]

  // major opcodes kept by this core
  localparam opcodeT OpCompute = 7'b0110011;  // register-register ALU
  localparam opcodeT OpImm     = 7'b0010011;  // register-immediate ALU
  localparam opcodeT OpBranch  = 7'b1100011;
  localparam opcodeT OpLui     = 7'b0110111;
  localparam opcodeT OpJal     = 7'b1101111;

  // ALU minor functions, shared by OpCompute and OpImm
  localparam funct3T F3Add  = 3'b000;  // sub when inst[30] set, register form only
  localparam funct3T F3Sll  = 3'b001;
  localparam funct3T F3Slt  = 3'b010;
  localparam funct3T F3Sltu = 3'b011;
  localparam funct3T F3Xor  = 3'b100;
  localparam funct3T F3Sr   = 3'b101;  // sra when inst[30] set
  localparam funct3T F3Or   = 3'b110;
  localparam funct3T F3And  = 3'b111;

  // branch conditions
  localparam funct3T F3Beq  = 3'b000;
  localparam funct3T F3Bne  = 3'b001;
  localparam funct3T F3Blt  = 3'b100;
  localparam funct3T F3Bge  = 3'b101;
  localparam funct3T F3Bltu = 3'b110;
  localparam funct3T F3Bgeu = 3'b111;

  // fetch control
  typedef enum logic [1:0]
  {
    FetchRun,      // fetching one word per cycle
    FetchStopped,  // zero word seen, waiting for the pipe to empty
    FetchHalted    // done until reset
  } fetchStateT;

endpackage

`default_nettype wire

// File: sources.f
rvPkg.sv
stageIf.sv
fetchUnit.sv
executeUnit.sv
writebackUnit.sv
pipelineCpu.sv
tbPipelineCpu.sv

// File: stageIf.sv
//*********************************************************************
// Bundles between the execute and writeback units. Operand data comes
// back combinationally and is already forwarded.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

// register reads for the instruction in execute
interface operandIf import rvPkg::*; ();
  regAddrT rs1;
  regAddrT rs2;
  wordT    rs1Data;  // forwarded, zero for x0
  wordT    rs2Data;

  modport exec (output rs1, output rs2, input rs1Data, input rs2Data);
  modport regs (input rs1, input rs2, output rs1Data, output rs2Data);
endinterface

// execute result heading for the memory slot
interface resultIf import rvPkg::*; ();
  logic    valid;    // live instruction, writing or not
  logic    writeEn;  // only with valid and a nonzero dst
  regAddrT dst;
  wordT    data;

  modport source (output valid, output writeEn, output dst, output data);
  modport sink (input valid, input writeEn, input dst, input data);
endinterface

`default_nettype wire

// File: tbPipelineCpu.sv
//*********************************************************************
// Directed testbench for the RV32I pipeline. Programs are served from
// a queue on the fetch port, and retires are compared in order with an
// in-order reference model. Every program must write a register first.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tbPipelineCpu import rvPkg::*;
();
  localparam wordT ResetPc = 32'h0000_0100;

  logic    clk;
  logic    reset;
  wordT    instAddr;
  wordT    instWord;
  logic    halt;
  logic    retireValid;
  regAddrT retireDst;
  wordT    retireData;

  wordT        prog [$];       // program words from ResetPc upwards
  logic [36:0] expQ [$];       // {dst, data} in program order
  logic [36:0] gotQ [$];
  logic        collecting;
  int          lateRetires;    // retires seen with halt high
  int          errors;
  int          checks;
  int          tests;
  int          failedTests;
  int          budget = 40;    // watchdog limit in cycles, grows per test
  int          cycles;
  wordT        rngState;

  pipelineCpu #(.ResetPc(ResetPc)) i_pipelineCpu
  (
    .clk(clk), .reset(reset),
    .instAddr(instAddr), .instWord(instWord),
    .halt(halt),
    .retireValid(retireValid), .retireDst(retireDst), .retireData(retireData)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  function automatic wordT nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // instruction encoders, all fields taken from the low bits
  function automatic wordT rType(input int f7, input int rs2, input int rs1,
                                 input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OpCompute};
  endfunction

  function automatic wordT iType(input int imm, input int rs1, input int f3, input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OpImm};
  endfunction

  function automatic wordT luiEnc(input int rd, input wordT upperVal);
    return {upperVal[31:12], rd[4:0], OpLui};
  endfunction

  function automatic wordT bEnc(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OpBranch};
  endfunction

  function automatic wordT jEnc(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OpJal};
  endfunction

  // word at a fetch address, zero outside the program
  function automatic wordT fetchWord(input wordT addr);
    int idx;
    if ($isunknown(addr))
      return '0;
    idx = int'((addr - ResetPc) >> 2);
    if (idx >= 0 && idx < prog.size())
      return prog[idx];
    return '0;
  endfunction

  // lui plus addi, upper part rounded for the sign of the low 12 bits
  task automatic loadConst(input int rd, input wordT value);
    wordT upper;
    upper = value + 32'h800;
    prog.push_back(luiEnc(rd, upper));
    prog.push_back(iType(value, rd, 0, rd));
  endtask

  function automatic wordT aluModel(input wordT inst, input wordT a, input wordT b);
    logic [4:0] sh;
    wordT       res;
    sh = b[4:0];
    case (inst[14:12])
      3'b000: res = (inst[6:0] == OpCompute && inst[30]) ? a - b : a + b;
      3'b001: res = a << sh;
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101:
        if (inst[30])
          res = $signed(a) >>> sh;  // arithmetic, keeps the sign
        else
          res = a >> sh;
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic takenModel(input logic [2:0] f3, input wordT a, input wordT b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return !($signed(a) < $signed(b));
      3'b110: return a < b;
      3'b111: return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  // runs the program in order and queues every nonzero register write
  task automatic buildExpected();
    wordT    regs [32];
    wordT    pc;
    wordT    nextPc;
    wordT    inst;
    wordT    a;
    wordT    b;
    wordT    val;
    regAddrT rd;
    logic    writes;
    foreach (regs[k])
      regs[k] = '0;
    expQ.delete();
    pc = ResetPc;
    for (int steps = 0; steps < 256; steps++)
    begin
      inst = fetchWord(pc);
      if (inst == '0)
        break;  // zero word stops the program
      rd = inst[11:7];
      a = regs[inst[19:15]];
      b = (inst[6:0] == OpCompute) ? regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
      writes = 1'b1;
      val = '0;
      nextPc = pc + 32'd4;
      case (inst[6:0])
        OpCompute, OpImm: val = aluModel(inst, a, b);
        OpLui: val = {inst[31:12], 12'h000};
        OpJal:
        begin
          val = pc + 32'd4;
          nextPc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OpBranch:
        begin
          writes = 1'b0;
          if (takenModel(inst[14:12], a, regs[inst[24:20]]))
            nextPc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        default: writes = 1'b0;
      endcase
      if (writes && rd != '0)
      begin
        regs[rd] = val;
        expQ.push_back({rd, val});
      end
      pc = nextPc;
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  // reset, run to halt, then compare retires with the model
  task automatic runProgram(input string name);
    int errorsBefore;
    int n;
    errorsBefore = errors;
    tests++;
    budget += (prog.size() + 6) * 20;
    buildExpected();
    applyReset();
    gotQ.delete();
    lateRetires = 0;
    collecting = 1'b1;
    @(negedge clk);
    checks++;
    if (halt !== 1'b0 || retireValid !== 1'b0 || instAddr !== ResetPc)
    begin
      $display("[ERROR] %0t: %s after reset halt=%b retireValid=%b instAddr=%h",
               $time, name, halt, retireValid, instAddr);
      errors++;
    end
    while (halt !== 1'b1)
      @(negedge clk);
    repeat (4) @(negedge clk);  // halt must stay quiet
    collecting = 1'b0;
    n = (gotQ.size() < expQ.size()) ? gotQ.size() : expQ.size();
    for (int i = 0; i < n; i++)
    begin
      checks++;
      if (gotQ[i] !== expQ[i])
      begin
        $display("[ERROR] %0t: %s retire %0d got x%0d=%h, expected x%0d=%h", $time, name,
                 i, gotQ[i][36:32], gotQ[i][31:0], expQ[i][36:32], expQ[i][31:0]);
        errors++;
      end
    end
    checks++;
    if (gotQ.size() > expQ.size())
    begin
      $display("%s: %0d retires more than expected", name, gotQ.size() - expQ.size());
      errors++;
    end
    else if (gotQ.size() < expQ.size())
    begin
      $display("%s: %0d expected retires never came", name, expQ.size() - gotQ.size());
      errors++;
    end
    checks++;
    if (lateRetires != 0)
    begin
      $display("%s: %0d retires while halt was high", name, lateRetires);
      errors++;
    end
    if (errors != errorsBefore)
      failedTests++;
    $display("test %-10s %0d retires, %0d errors", name, gotQ.size(), errors - errorsBefore);
  endtask

  task automatic resetTest();
    prog.delete();
    prog.push_back(iType(5, 0, 0, 1));  // addi x1, x0, 5
    runProgram("reset");
  endtask

  // each op reads the previous result and the one before it
  task automatic aluChainTest();
    int f3s [10] = '{0, 0, 1, 5, 5, 2, 3, 4, 6, 7};
    int f7s [10] = '{0, 32, 0, 0, 32, 0, 0, 0, 0, 0};
    int rs1;
    int rs2;
    prog.delete();
    for (int round = 0; round < 2; round++)
    begin
      loadConst(1, nextRand());
      loadConst(2, nextRand());
      for (int i = 0; i < 10; i++)
      begin
        rs1 = (i == 0) ? 1 : 2 + i;  // memory slot source
        rs2 = (i < 2) ? 2 : 1 + i;   // writeback slot source
        prog.push_back(rType(f7s[i], rs2, rs1, f3s[i], 3 + i));
      end
    end
    runProgram("alu chain");
  endtask

  task automatic immTest();
    prog.delete();
    loadConst(1, nextRand());
    loadConst(2, nextRand() | 32'h8000_0000);  // negative source
    prog.push_back(iType(-5, 1, 0, 3));
    prog.push_back(iType(-100, 2, 2, 4));
    prog.push_back(iType(-1, 3, 3, 5));
    prog.push_back(iType(-1, 1, 4, 6));
    prog.push_back(iType(int'(nextRand()), 6, 6, 7));
    prog.push_back(iType(-256, 7, 7, 8));
    prog.push_back(iType(7, 2, 1, 9));
    prog.push_back(iType(13, 2, 5, 10));
    prog.push_back(iType(32'h400 | 31, 2, 5, 11));  // srai by 31
    prog.push_back(iType(32'h400 | (nextRand() & 31), 1, 5, 12));
    prog.push_back(iType(int'(nextRand()), 12, 0, 13));
    runProgram("immediate");
  endtask

  // x1 = -1 and x2 = 1 split signed from unsigned order
  task automatic branchTest();
    int f3s [6] = '{0, 1, 4, 5, 6, 7};
    int takenA [6] = '{2, 1, 1, 2, 2, 1};
    int takenB [6] = '{2, 2, 2, 1, 1, 2};
    int notA [6] = '{1, 2, 2, 1, 1, 2};
    int notB [6] = '{2, 2, 1, 2, 2, 1};
    int k;
    prog.delete();
    loadConst(1, 32'hffff_ffff);
    loadConst(2, 32'd1);
    for (int c = 0; c < 12; c++)
    begin
      k = c % 6;
      if (c < 6)
        prog.push_back(bEnc(f3s[k], takenA[k], takenB[k], 12));
      else
        prog.push_back(bEnc(f3s[k], notA[k], notB[k], 12));
      prog.push_back(iType(3 * c + 1, 0, 0, 5));  // squashed when taken
      prog.push_back(iType(3 * c + 2, 0, 0, 6));
      prog.push_back(iType(3 * c + 3, 0, 0, 7));  // target
    end
    runProgram("branch");
  endtask

  task automatic jalTest();
    prog.delete();
    prog.push_back(iType(3, 0, 0, 1));
    prog.push_back(jEnc(2, 12));
    prog.push_back('0);                  // zero word on the wrong path
    prog.push_back(iType(4, 0, 0, 4));
    prog.push_back(iType(9, 1, 0, 5));   // jal target
    prog.push_back(jEnc(6, 8));
    prog.push_back(iType(7, 0, 0, 7));
    prog.push_back(rType(0, 6, 2, 0, 8)); // sums both return addresses
    runProgram("jal");
  endtask

  task automatic haltTest();
    prog.delete();
    prog.push_back(iType(11, 0, 0, 1));
    prog.push_back(iType(1, 1, 0, 2));
    prog.push_back(rType(0, 2, 1, 0, 3));
    prog.push_back(iType(-2, 3, 0, 4));
    prog.push_back('0);
    prog.push_back(iType(99, 0, 0, 9));  // past the stop, never fetched
    runProgram("halt");
  endtask

  // program server, drives the word for the new fetch address
  initial
  begin
    forever
    begin
      @(posedge clk);
      #1 instWord = fetchWord(instAddr);
    end
  end

  // retire monitor
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (collecting && retireValid === 1'b1)
      begin
        gotQ.push_back({retireDst, retireData});
        if (halt)
          lateRetires++;
      end
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles <= budget)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, fetch state %s", cycles,
             i_pipelineCpu.i_fetchUnit.state.name());
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    reset = 1'b1;
    instWord = '0;
    collecting = 1'b0;
    lateRetires = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    failedTests = 0;
    rngState = 32'hf9ff;
    resetTest();
    aluChainTest();
    immTest();
    branchTest();
    jalTest();
    haltTest();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failedTests, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: writebackUnit.sv
//*********************************************************************
// Memory slot is a plain pipeline register, there is no data memory.
// The register file has no reset, write a register before reading it.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module writebackUnit import rvPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  operandIf.regs  operands,
  resultIf.sink   result,
  output logic    retireValid,
  output regAddrT retireDst,
  output wordT    retireData,
  output logic    drained
);
  logic    memValid;
  logic    memWriteEn;
  regAddrT memDst;
  wordT    memData;
  logic    wbValid;
  logic    wbWriteEn;
  regAddrT wbDst;
  wordT    wbData;
  wordT    regFile [32];

  // newest producer wins, x0 reads as zero
  function automatic wordT forward(input regAddrT idx);
    wordT value;
    if (idx == '0)
      value = '0;
    else if (memWriteEn && (memDst == idx))
      value = memData;
    else if (wbWriteEn && (wbDst == idx))
      value = wbData;
    else
      value = regFile[idx];
    return value;
  endfunction

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      memValid <= 1'b0;
      memWriteEn <= 1'b0;
      wbValid <= 1'b0;
      wbWriteEn <= 1'b0;
    end
    else
    begin
      memValid <= result.valid;
      memWriteEn <= result.writeEn;
      wbValid <= memValid;
      wbWriteEn <= memWriteEn;
    end
  end

  always_ff @(posedge clk)
  begin
    memDst <= result.dst;
    memData <= result.data;
    wbDst <= memDst;
    wbData <= memData;
  end

  // write at the end of writeback, visible to execute on the next cycle
  always_ff @(posedge clk)
  begin
    if (wbWriteEn && (wbDst != '0))
      regFile[wbDst] <= wbData;
  end

  always_comb
  begin
    operands.rs1Data = forward(operands.rs1);
    operands.rs2Data = forward(operands.rs2);
  end

  assign retireValid = wbWriteEn;  // one write per cycle, same slot as the file
  assign retireDst = wbDst;
  assign retireData = wbData;
  assign drained = !memValid && !wbValid;

  // execute filters x0 writes, so none ever reaches retire
  assert property (@(posedge clk) disable iff (reset) retireValid |-> retireDst != '0)
    else $error("retire to x0");

endmodule

`default_nettype wire
